// File: hw/muldiv_settings.svh
// Sizing of the multiply/divide unit
// XLEN stays 32 because the word (W) forms are not implemented
// MUL_LATENCY must be at least 1

`ifndef MULDIV_SETTINGS_SVH
`define MULDIV_SETTINGS_SVH

// Operand width of one lane
`define XLEN 32

// Parallel SIMT lanes handled per request
`define NUM_LANES 4

// Register stages in the multiplier
`define MUL_LATENCY 3

// Opaque tag (warp id, rd and the like) that comes back with the result
`define MULDIV_TAG_W 8

`endif

// File: hw/muldiv_pkg.sv
// Operation encoding and lane types of the multiply/divide unit
// Bit 2 of the operation code separates the divider class from the multiplier class

`include "muldiv_settings.svh"

package muldiv_pkg;

    // Same order as funct3 of the RISC-V M extension
    typedef enum logic [2:0] {
        op_mul    = 3'b000,
        op_mulh   = 3'b001,
        op_mulhsu = 3'b010,
        op_mulhu  = 3'b011,
        op_div    = 3'b100,
        op_divu   = 3'b101,
        op_rem    = 3'b110,
        op_remu   = 3'b111
    } muldiv_op_e;

    typedef logic [`XLEN-1:0] lane_word_t;

    // Lane 0 sits in the low bits
    typedef lane_word_t [`NUM_LANES-1:0] lane_data_t;

    typedef logic [`NUM_LANES-1:0] lane_mask_t;

    typedef logic [`MULDIV_TAG_W-1:0] tag_t;

endpackage

// File: hw/mul_pipe.sv
// Fully pipelined lane multiplier with a global stall
// The whole pipe advances together, so only a bubble at the output is collapsed

`timescale 1ns/100ps
`include "muldiv_settings.svh"

module mul_pipe (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  muldiv_pkg::muldiv_op_e in_op,
    input  muldiv_pkg::tag_t       in_tag,
    input  muldiv_pkg::lane_mask_t in_mask,
    input  muldiv_pkg::lane_data_t in_a,
    input  muldiv_pkg::lane_data_t in_b,
    input  logic                   out_ready,
    output logic                   in_ready,
    output logic                   out_valid,
    output muldiv_pkg::tag_t       out_tag,
    output muldiv_pkg::lane_mask_t out_mask,
    output muldiv_pkg::lane_data_t out_data
);

    localparam int LAT = `MUL_LATENCY;
    localparam int PW = 2 * `XLEN;

    logic a_signed;
    logic b_signed;
    logic [`NUM_LANES-1:0][PW-1:0] prod;

    logic [LAT-1:0] vld_q;
    logic [LAT-1:0] hi_q;
    muldiv_pkg::tag_t [LAT-1:0] tag_q;
    muldiv_pkg::lane_mask_t [LAT-1:0] mask_q;
    logic [LAT-1:0][`NUM_LANES-1:0][PW-1:0] prod_q;

    // MULHSU treats only rs1 as signed, MULHU neither operand
    assign a_signed = (in_op == muldiv_pkg::op_mulh) || (in_op == muldiv_pkg::op_mulhsu);
    assign b_signed = (in_op == muldiv_pkg::op_mulh);

    assign in_ready = out_ready || !out_valid;

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        logic signed [`XLEN:0] a_ext;
        logic signed [`XLEN:0] b_ext;
        logic signed [PW+1:0] full;

        // One extra bit lets a single signed multiplier cover all four variants
        assign a_ext = {a_signed & in_a[i][`XLEN-1], in_a[i]};
        assign b_ext = {b_signed & in_b[i][`XLEN-1], in_b[i]};
        assign full = a_ext * b_ext;
        assign prod[i] = full[PW-1:0];

        assign out_data[i] = hi_q[LAT-1] ? prod_q[LAT-1][i][PW-1:`XLEN]
                                         : prod_q[LAT-1][i][`XLEN-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else if (in_ready) begin
            vld_q[0] <= in_valid;
            for (int s = 1; s < LAT; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready) begin
            hi_q[0] <= (in_op != muldiv_pkg::op_mul);
            tag_q[0] <= in_tag;
            mask_q[0] <= in_mask;
            prod_q[0] <= prod;
            for (int s = 1; s < LAT; s++) begin
                hi_q[s] <= hi_q[s-1];
                tag_q[s] <= tag_q[s-1];
                mask_q[s] <= mask_q[s-1];
                prod_q[s] <= prod_q[s-1];
            end
        end
    end

    assign out_valid = vld_q[LAT-1];
    assign out_tag = tag_q[LAT-1];
    assign out_mask = mask_q[LAT-1];

    // A stalled result must not change under the arbiter
    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_data));

endmodule

// File: hw/div_ctrl.sv
// Sequencer of the serial divider, one division in flight at a time
// The accept cycle loads the operands and XLEN step cycles follow

`timescale 1ns/100ps
`include "muldiv_settings.svh"

module div_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  muldiv_pkg::tag_t       in_tag,
    input  muldiv_pkg::lane_mask_t in_mask,
    input  logic                   last_step,
    input  logic                   out_ready,
    output logic                   in_ready,
    output logic                   start,
    output logic                   step_en,
    output logic                   out_valid,
    output muldiv_pkg::tag_t       out_tag,
    output muldiv_pkg::lane_mask_t out_mask
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } state_e;

    state_e state;

    assign in_ready = (state == st_idle);
    assign start = in_valid && in_ready;
    assign step_en = (state == st_run);
    assign out_valid = (state == st_done);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_run;
                    end
                end
                st_run: begin
                    if (last_step) begin
                        state <= st_done;
                    end
                end
                st_done: begin
                    if (out_ready) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Tag and mask wait here while the datapath iterates
    always_ff @(posedge clk) begin
        if (start) begin
            out_tag <= in_tag;
            out_mask <= in_mask;
        end
    end

    // The step counter has expired whenever the sequencer idles or a division starts
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        (start || (state == st_idle)) |-> !last_step);

endmodule

// File: hw/div_step_counter.sv
// Step counter of the serial divider
// The count sits one below zero while no division is running

`timescale 1ns/100ps
`include "muldiv_settings.svh"

module div_step_counter (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic step_en,
    output logic last_step
);

    // The extra top bit marks an expired count
    localparam int CNT_W = $clog2(`XLEN) + 1;

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '1;
        end else if (start) begin
            count <= CNT_W'(`XLEN - 1);
        end else if (step_en) begin
            count <= count - 1'b1;
        end
    end

    assign last_step = (count == '0);

    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        step_en |-> !count[CNT_W-1]);

endmodule

// File: hw/div_datapath.sv
// Per-lane restoring divider on magnitudes, one quotient bit per step
// Operands are sampled only on start, the result is valid after the last step

`timescale 1ns/100ps
`include "muldiv_settings.svh"

module div_datapath (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   step_en,
    input  muldiv_pkg::muldiv_op_e in_op,
    input  muldiv_pkg::lane_data_t in_a,
    input  muldiv_pkg::lane_data_t in_b,
    output muldiv_pkg::lane_data_t out_data
);

    logic is_signed;
    logic is_rem_q;

    assign is_signed = (in_op == muldiv_pkg::op_div) || (in_op == muldiv_pkg::op_rem);

    always_ff @(posedge clk) begin
        if (rst) begin
            is_rem_q <= 1'b0;
        end else if (start) begin
            is_rem_q <= (in_op == muldiv_pkg::op_rem) || (in_op == muldiv_pkg::op_remu);
        end
    end

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        logic a_neg;
        logic b_neg;
        logic [`XLEN-1:0] a_mag;
        logic [`XLEN-1:0] b_mag;
        logic [`XLEN-1:0] quo_q;
        logic [`XLEN-1:0] rem_q;
        logic [`XLEN-1:0] dvs_q;
        logic neg_quo_q;
        logic neg_rem_q;
        logic [`XLEN:0] trial;
        logic [`XLEN:0] diff;
        logic [`XLEN-1:0] quo_res;
        logic [`XLEN-1:0] rem_res;

        assign a_neg = is_signed && in_a[i][`XLEN-1];
        assign b_neg = is_signed && in_b[i][`XLEN-1];
        assign a_mag = a_neg ? -in_a[i] : in_a[i];
        assign b_mag = b_neg ? -in_b[i] : in_b[i];

        // Shift in the next dividend bit and try to subtract the divisor
        assign trial = {rem_q, quo_q[`XLEN-1]};
        assign diff = trial - {1'b0, dvs_q};

        always_ff @(posedge clk) begin
            if (rst) begin
                neg_quo_q <= 1'b0;
                neg_rem_q <= 1'b0;
            end else if (start) begin
                // Division by zero must return all ones, so its quotient is never negated
                neg_quo_q <= (a_neg ^ b_neg) && (in_b[i] != '0);
                neg_rem_q <= a_neg;
            end
        end

        always_ff @(posedge clk) begin
            if (start) begin
                quo_q <= a_mag;
                rem_q <= '0;
                dvs_q <= b_mag;
            end else if (step_en) begin
                if (diff[`XLEN]) begin
                    rem_q <= trial[`XLEN-1:0];
                    quo_q <= {quo_q[`XLEN-2:0], 1'b0};
                end else begin
                    rem_q <= diff[`XLEN-1:0];
                    quo_q <= {quo_q[`XLEN-2:0], 1'b1};
                end
            end
        end

        // With a zero divisor every step succeeds, so the quotient fills with ones and
        // the remainder ends up as the dividend. The overflow case (min / -1) yields
        // a quotient of 2^(XLEN-1) unnegated, which equals the dividend, and remainder 0
        assign quo_res = neg_quo_q ? -quo_q : quo_q;
        assign rem_res = neg_rem_q ? -rem_q : rem_q;

        assign out_data[i] = is_rem_q ? rem_res : quo_res;
    end

endmodule

// File: hw/commit_arb.sv
// Two-input round-robin arbiter into a registered commit port
// The output register reloads in the cycle it is drained, so a full stream needs no bubbles

`timescale 1ns/100ps

module commit_arb (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mul_valid,
    input  muldiv_pkg::tag_t       mul_tag,
    input  muldiv_pkg::lane_mask_t mul_mask,
    input  muldiv_pkg::lane_data_t mul_data,
    input  logic                   div_valid,
    input  muldiv_pkg::tag_t       div_tag,
    input  muldiv_pkg::lane_mask_t div_mask,
    input  muldiv_pkg::lane_data_t div_data,
    input  logic                   commit_ready,
    output logic                   mul_ready,
    output logic                   div_ready,
    output logic                   commit_valid,
    output muldiv_pkg::tag_t       commit_tag,
    output muldiv_pkg::lane_mask_t commit_mask,
    output muldiv_pkg::lane_data_t commit_data
);

    logic prio_div;
    logic can_load;
    logic grant_mul;
    logic grant_div;

    assign can_load = !commit_valid || commit_ready;

    assign grant_div = div_valid && (!mul_valid || prio_div);
    assign grant_mul = mul_valid && !grant_div;

    assign mul_ready = can_load && grant_mul;
    assign div_ready = can_load && grant_div;

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
            prio_div <= 1'b0;
        end else if (can_load) begin
            commit_valid <= mul_valid || div_valid;
            // The loser of a contended cycle wins the next one
            if (mul_valid && div_valid) begin
                prio_div <= grant_mul;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (can_load) begin
            if (grant_div) begin
                commit_tag <= div_tag;
                commit_mask <= div_mask;
                commit_data <= div_data;
            end else begin
                commit_tag <= mul_tag;
                commit_mask <= mul_mask;
                commit_data <= mul_data;
            end
        end
    end

    a_commit_hold: assert property (@(posedge clk) disable iff (rst)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_tag));

endmodule

// File: hw/muldiv_unit.sv
// Integer multiply/divide execution unit, RISC-V M extension for XLEN 32
// Results may leave out of request order and the tag identifies each one

`timescale 1ns/100ps

module muldiv_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  muldiv_pkg::muldiv_op_e req_op,
    input  muldiv_pkg::tag_t       req_tag,
    input  muldiv_pkg::lane_mask_t req_mask,
    input  muldiv_pkg::lane_data_t req_rs1,
    input  muldiv_pkg::lane_data_t req_rs2,
    input  logic                   commit_ready,
    output logic                   req_ready,
    output logic                   commit_valid,
    output muldiv_pkg::tag_t       commit_tag,
    output muldiv_pkg::lane_mask_t commit_mask,
    output muldiv_pkg::lane_data_t commit_data
);

    logic is_div;

    logic mul_in_valid;
    logic mul_in_ready;
    logic mul_out_valid;
    logic mul_out_ready;
    muldiv_pkg::tag_t mul_out_tag;
    muldiv_pkg::lane_mask_t mul_out_mask;
    muldiv_pkg::lane_data_t mul_out_data;

    logic div_in_valid;
    logic div_in_ready;
    logic div_start;
    logic div_step_en;
    logic div_last_step;
    logic div_out_valid;
    logic div_out_ready;
    muldiv_pkg::tag_t div_out_tag;
    muldiv_pkg::lane_mask_t div_out_mask;
    muldiv_pkg::lane_data_t div_out_data;

    // Top opcode bit selects the divider
    assign is_div = req_op[2];

    assign mul_in_valid = req_valid && !is_div;
    assign div_in_valid = req_valid && is_div;

    // A busy divider only blocks divides
    assign req_ready = is_div ? div_in_ready : mul_in_ready;

    mul_pipe u_mul_pipe (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (mul_in_valid),
        .in_op     (req_op),
        .in_tag    (req_tag),
        .in_mask   (req_mask),
        .in_a      (req_rs1),
        .in_b      (req_rs2),
        .out_ready (mul_out_ready),
        .in_ready  (mul_in_ready),
        .out_valid (mul_out_valid),
        .out_tag   (mul_out_tag),
        .out_mask  (mul_out_mask),
        .out_data  (mul_out_data)
    );

    div_ctrl u_div_ctrl (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (div_in_valid),
        .in_tag    (req_tag),
        .in_mask   (req_mask),
        .last_step (div_last_step),
        .out_ready (div_out_ready),
        .in_ready  (div_in_ready),
        .start     (div_start),
        .step_en   (div_step_en),
        .out_valid (div_out_valid),
        .out_tag   (div_out_tag),
        .out_mask  (div_out_mask)
    );

    div_step_counter u_div_step_counter (
        .clk       (clk),
        .rst       (rst),
        .start     (div_start),
        .step_en   (div_step_en),
        .last_step (div_last_step)
    );

    div_datapath u_div_datapath (
        .clk      (clk),
        .rst      (rst),
        .start    (div_start),
        .step_en  (div_step_en),
        .in_op    (req_op),
        .in_a     (req_rs1),
        .in_b     (req_rs2),
        .out_data (div_out_data)
    );

    commit_arb u_commit_arb (
        .clk          (clk),
        .rst          (rst),
        .mul_valid    (mul_out_valid),
        .mul_tag      (mul_out_tag),
        .mul_mask     (mul_out_mask),
        .mul_data     (mul_out_data),
        .div_valid    (div_out_valid),
        .div_tag      (div_out_tag),
        .div_mask     (div_out_mask),
        .div_data     (div_out_data),
        .commit_ready (commit_ready),
        .mul_ready    (mul_out_ready),
        .div_ready    (div_out_ready),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .commit_mask  (commit_mask),
        .commit_data  (commit_data)
    );

    a_req_op_known: assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready |-> !$isunknown(req_op));

endmodule

// File: test/muldiv_tb.sv
// Self-checking testbench for muldiv_unit with a request table whose index is the tag
// The table and the reference model assume XLEN 32 and four lanes
// Lanes outside the request mask are not compared

`timescale 1ns/100ps
`include "muldiv_settings.svh"

module muldiv_tb;

    localparam int MAX_TAGS = 1 << `MULDIV_TAG_W;
    localparam int REQ_TIMEOUT = 500;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int NUM_RANDOM = 16;

    logic clk = 1'b0;
    logic rst;
    logic req_valid;
    muldiv_pkg::muldiv_op_e req_op;
    muldiv_pkg::tag_t req_tag;
    muldiv_pkg::lane_mask_t req_mask;
    muldiv_pkg::lane_data_t req_rs1;
    muldiv_pkg::lane_data_t req_rs2;
    logic commit_ready = 1'b1;
    logic req_ready;
    logic commit_valid;
    muldiv_pkg::tag_t commit_tag;
    muldiv_pkg::lane_mask_t commit_mask;
    muldiv_pkg::lane_data_t commit_data;

    // Stimulus table, a nonzero latency marks an entry whose commit time is checked
    muldiv_pkg::muldiv_op_e tbl_op [MAX_TAGS];
    muldiv_pkg::lane_data_t tbl_rs1 [MAX_TAGS];
    muldiv_pkg::lane_data_t tbl_rs2 [MAX_TAGS];
    muldiv_pkg::lane_mask_t tbl_mask [MAX_TAGS];
    int tbl_lat [MAX_TAGS];
    int num_entries = 0;
    int timed_first;
    int random_first;

    muldiv_pkg::lane_data_t exp_data [MAX_TAGS];
    bit sent [MAX_TAGS];
    bit received [MAX_TAGS];
    int accept_edge [MAX_TAGS];
    int first_seen [MAX_TAGS];
    int commit_order [MAX_TAGS];
    int sent_count = 0;
    int recv_count = 0;
    int error_count = 0;

    integer seed = 68279;
    integer rnd;
    bit rand_ready = 1'b0;
    int cycle_cnt = 0;

    muldiv_unit uut (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_op       (req_op),
        .req_tag      (req_tag),
        .req_mask     (req_mask),
        .req_rs1      (req_rs1),
        .req_rs2      (req_rs2),
        .commit_ready (commit_ready),
        .req_ready    (req_ready),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .commit_mask  (commit_mask),
        .commit_data  (commit_data)
    );

    always #5 clk = ~clk;

    // Edge number, so cycle_cnt equals N right after rising edge N
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    always @(posedge clk) begin
        rnd = $random(seed);
        commit_ready <= rand_ready ? rnd[0] : 1'b1;
    end

    task automatic report_failure(input string why);
        begin
            error_count++;
            $display("%s", why);
            $display("SIMULATION FAILED");
            $fatal(1, "Stopped at the first error");
        end
    endtask

    task automatic check_data(input string name, input muldiv_pkg::lane_mask_t mask,
                              input muldiv_pkg::lane_data_t expected,
                              input muldiv_pkg::lane_data_t actual);
        begin
            for (int i = 0; i < `NUM_LANES; i++) begin
                if (mask[i] && (actual[i] !== expected[i])) begin
                    report_failure($sformatf("[ERROR] %s lane %0d data: expected %h, actual %h",
                                             name, i, expected[i], actual[i]));
                end
            end
        end
    endtask

    task automatic check_mask(input string name, input muldiv_pkg::lane_mask_t expected,
                              input muldiv_pkg::lane_mask_t actual);
        begin
            if (actual !== expected) begin
                report_failure($sformatf("[ERROR] %s mask: expected %b, actual %b",
                                         name, expected, actual));
            end
        end
    endtask

    task automatic check_tag(input muldiv_pkg::tag_t tag);
        begin
            if (int'(tag) >= num_entries || !sent[tag]) begin
                report_failure($sformatf("A result came back with tag %0d that was never issued",
                                         tag));
            end else if (received[tag]) begin
                report_failure($sformatf("The result with tag %0d came back twice", tag));
            end
        end
    endtask

    task automatic check_count(input int expected, input int actual);
        begin
            if (actual != expected) begin
                report_failure($sformatf("[ERROR] result count: expected %0d, actual %0d",
                                         expected, actual));
            end
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        begin
            if (actual != expected) begin
                report_failure($sformatf("[ERROR] %s commit latency: expected %0d, actual %0d",
                                         name, expected, actual));
            end
        end
    endtask

    function automatic string entry_name(input muldiv_pkg::tag_t tag);
        return $sformatf("entry %0d %s", tag, tbl_op[tag].name());
    endfunction

    function automatic muldiv_pkg::lane_data_t lanes(input muldiv_pkg::lane_word_t w0,
                                                     input muldiv_pkg::lane_word_t w1,
                                                     input muldiv_pkg::lane_word_t w2,
                                                     input muldiv_pkg::lane_word_t w3);
        muldiv_pkg::lane_data_t res;
        begin
            res[0] = w0;
            res[1] = w1;
            res[2] = w2;
            res[3] = w3;
            return res;
        end
    endfunction

    // One lane under the RISC-V M rules, with 64-bit products taken modulo 2^64
    function automatic muldiv_pkg::lane_word_t ref_lane(input muldiv_pkg::muldiv_op_e op,
                                                        input muldiv_pkg::lane_word_t a,
                                                        input muldiv_pkg::lane_word_t b);
        logic [63:0] a_sx;
        logic [63:0] a_zx;
        logic [63:0] b_sx;
        logic [63:0] b_zx;
        logic [63:0] prod;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic overflow;
        begin
            a_sx = {{32{a[31]}}, a};
            a_zx = {32'h0, a};
            b_sx = {{32{b[31]}}, b};
            b_zx = {32'h0, b};
            sa = a;
            sb = b;
            overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
            case (op)
                muldiv_pkg::op_mul: begin
                    prod = a_zx * b_zx;
                    return prod[31:0];
                end
                muldiv_pkg::op_mulh: begin
                    prod = a_sx * b_sx;
                    return prod[63:32];
                end
                muldiv_pkg::op_mulhsu: begin
                    prod = a_sx * b_zx;
                    return prod[63:32];
                end
                muldiv_pkg::op_mulhu: begin
                    prod = a_zx * b_zx;
                    return prod[63:32];
                end
                muldiv_pkg::op_div: begin
                    if (b == '0) return '1;
                    if (overflow) return a;
                    return sa / sb;
                end
                muldiv_pkg::op_divu: begin
                    if (b == '0) return '1;
                    return a / b;
                end
                muldiv_pkg::op_rem: begin
                    if (b == '0) return a;
                    if (overflow) return '0;
                    return sa % sb;
                end
                default: begin
                    if (b == '0) return a;
                    return a % b;
                end
            endcase
        end
    endfunction

    function automatic muldiv_pkg::lane_data_t ref_model(input muldiv_pkg::muldiv_op_e op,
                                                         input muldiv_pkg::lane_data_t a,
                                                         input muldiv_pkg::lane_data_t b);
        muldiv_pkg::lane_data_t res;
        begin
            for (int i = 0; i < `NUM_LANES; i++) begin
                res[i] = ref_lane(op, a[i], b[i]);
            end
            return res;
        end
    endfunction

    task automatic add_entry(input muldiv_pkg::muldiv_op_e op, input muldiv_pkg::lane_data_t a,
                             input muldiv_pkg::lane_data_t b, input muldiv_pkg::lane_mask_t mask,
                             input int lat);
        begin
            tbl_op[num_entries] = op;
            tbl_rs1[num_entries] = a;
            tbl_rs2[num_entries] = b;
            tbl_mask[num_entries] = mask;
            tbl_lat[num_entries] = lat;
            num_entries++;
        end
    endtask

    task automatic fill_table();
        muldiv_pkg::lane_data_t m_a0;
        muldiv_pkg::lane_data_t m_b0;
        muldiv_pkg::lane_data_t m_a1;
        muldiv_pkg::lane_data_t m_b1;
        muldiv_pkg::lane_data_t d_a0;
        muldiv_pkg::lane_data_t d_b0;
        muldiv_pkg::lane_data_t d_a1;
        muldiv_pkg::lane_data_t d_b1;
        muldiv_pkg::lane_data_t ra;
        muldiv_pkg::lane_data_t rb;
        muldiv_pkg::lane_mask_t rmask;
        begin
            m_a0 = lanes(32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h1234_5678);
            m_b0 = lanes(32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h9abc_def0);
            m_a1 = lanes(32'h8000_0000, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0003);
            m_b1 = lanes(32'hffff_ffff, 32'h7fff_ffff, 32'hdead_beef, 32'hffff_fffd);
            // Lane 0 of d_a0/d_b0 is min / -1 and lane 1 divides by zero
            d_a0 = lanes(32'h8000_0000, 32'h0000_0007, 32'hffff_fff9, 32'h0000_0064);
            d_b0 = lanes(32'hffff_ffff, 32'h0000_0000, 32'h0000_0002, 32'hffff_fffd);
            d_a1 = lanes(32'hffff_ffff, 32'h8000_0000, 32'h0000_0000, 32'h7fff_ffff);
            d_b1 = lanes(32'h0000_0001, 32'h0000_0000, 32'h8000_0000, 32'hffff_ffff);
            for (int t = 0; t < MAX_TAGS; t++) begin
                sent[t] = 1'b0;
                received[t] = 1'b0;
                first_seen[t] = -1;
            end
            for (int k = 0; k < 4; k++) begin
                add_entry(muldiv_pkg::muldiv_op_e'(3'(k)), m_a0, m_b0, 4'hf, 0);
                add_entry(muldiv_pkg::muldiv_op_e'(3'(k)), m_a1, m_b1, 4'hd, 0);
                add_entry(muldiv_pkg::muldiv_op_e'(3'(k + 4)), d_a0, d_b0, 4'hf, 0);
                add_entry(muldiv_pkg::muldiv_op_e'(3'(k + 4)), d_a1, d_b1, 4'hd, 0);
            end
            // A divide with multiplies behind it that overtake it
            timed_first = num_entries;
            add_entry(muldiv_pkg::op_div, d_a0, d_b0, 4'h7, `XLEN + 1);
            add_entry(muldiv_pkg::op_mulhsu, m_a0, m_b0, 4'he, 0);
            add_entry(muldiv_pkg::op_mul, m_a1, m_b1, 4'h3, 0);
            add_entry(muldiv_pkg::op_mulh, m_a1, m_b0, 4'hf, 0);
            random_first = num_entries;
            for (int n = 0; n < NUM_RANDOM; n++) begin
                for (int l = 0; l < `NUM_LANES; l++) begin
                    ra[l] = $random(seed);
                    rb[l] = $random(seed);
                end
                rmask = muldiv_pkg::lane_mask_t'($random(seed)) | 4'h1;
                add_entry(muldiv_pkg::muldiv_op_e'(3'(n % 4)), ra, rb, rmask, 0);
            end
        end
    endtask

    task automatic send_request(input int idx);
        int waited;
        begin
            @(posedge clk);
            req_valid <= 1'b1;
            req_op <= tbl_op[idx];
            req_tag <= muldiv_pkg::tag_t'(idx);
            req_mask <= tbl_mask[idx];
            req_rs1 <= tbl_rs1[idx];
            req_rs2 <= tbl_rs2[idx];
            exp_data[idx] = ref_model(tbl_op[idx], tbl_rs1[idx], tbl_rs2[idx]);
            sent[idx] = 1'b1;
            sent_count++;
            waited = 0;
            @(negedge clk);
            while (!req_ready) begin
                waited++;
                if (waited > REQ_TIMEOUT) begin
                    report_failure($sformatf("Request %0d was never accepted", idx));
                end
                @(negedge clk);
            end
            // The transfer happens on the next rising edge
            accept_edge[idx] = cycle_cnt + 1;
        end
    endtask

    task automatic release_request();
        begin
            @(posedge clk);
            req_valid <= 1'b0;
        end
    endtask

    task automatic wait_drained();
        int waited;
        begin
            waited = 0;
            while (recv_count < sent_count) begin
                waited++;
                if (waited > DRAIN_TIMEOUT) begin
                    report_failure("Outstanding results did not come back in time");
                end
                @(negedge clk);
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst && commit_valid) begin
            if (first_seen[commit_tag] < 0) begin
                first_seen[commit_tag] = cycle_cnt;
            end
            if (commit_ready) begin
                check_tag(commit_tag);
                check_mask(entry_name(commit_tag), tbl_mask[commit_tag], commit_mask);
                check_data(entry_name(commit_tag), tbl_mask[commit_tag], exp_data[commit_tag],
                           commit_data);
                if (tbl_lat[commit_tag] != 0) begin
                    check_latency(entry_name(commit_tag), tbl_lat[commit_tag],
                                  first_seen[commit_tag] - accept_edge[commit_tag]);
                end
                received[commit_tag] = 1'b1;
                commit_order[commit_tag] = recv_count;
                recv_count++;
            end
        end
    end

    initial begin
        #1000000;
        report_failure("Watchdog expired before the test finished");
    end

    initial begin
        rst = 1'b1;
        req_valid = 1'b0;
        req_op = muldiv_pkg::op_mul;
        req_tag = '0;
        req_mask = '0;
        req_rs1 = '0;
        req_rs2 = '0;
        fill_table();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (commit_valid !== 1'b0) begin
            report_failure("commit_valid is not low after reset");
        end
        if (req_ready !== 1'b1) begin
            report_failure("req_ready is not high after reset");
        end

        // Corner cases of every operation under random back-pressure
        rand_ready = 1'b1;
        for (int i = 0; i < timed_first; i++) begin
            send_request(i);
        end
        release_request();
        wait_drained();

        rand_ready = 1'b0;
        for (int i = timed_first; i < random_first; i++) begin
            send_request(i);
        end
        release_request();
        wait_drained();
        for (int j = timed_first + 1; j < random_first; j++) begin
            if (commit_order[j] > commit_order[timed_first]) begin
                report_failure($sformatf("Multiply entry %0d committed after the older divide",
                                         j));
            end
        end

        rand_ready = 1'b1;
        for (int i = random_first; i < num_entries; i++) begin
            send_request(i);
        end
        release_request();
        wait_drained();

        check_count(num_entries, recv_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("SIMULATION FAILED");
            $fatal(1, "Errors were recorded");
        end
    end

endmodule

// File: vlog.f
+incdir+hw
hw/muldiv_pkg.sv
hw/mul_pipe.sv
hw/div_ctrl.sv
hw/div_step_counter.sv
hw/div_datapath.sv
hw/commit_arb.sv
hw/muldiv_unit.sv
test/muldiv_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it into sim.log and checks the log
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module muldiv_tb -f vlog.f -o muldiv_sim \
    && ./obj_dir/muldiv_sim > sim.log 2>&1 \
    || echo "Build or simulation returned an error status"
cat sim.log 2>/dev/null
grep -q "^SIMULATION PASSED$" sim.log 2>/dev/null \
    && echo "Run passed" \
    || { echo "Run failed"; exit 1; }
exit 0
